/* br_stack.sv */
`timescale 1ns/100ps
`default_nettype none

module br_stack #(
    parameter int depth = branch_pkg::branch_pred_sz
) (
    input  wire logic                                   clock,
    input  wire logic                                   reset,
    input  wire core_pkg::decoded_packet                dis_inst,
    input  wire branch_pkg::map_vec                     cur_map,
    input  wire core_pkg::fl_ptr                        in_fl_head,
    input  wire core_pkg::rob_ptr                       in_rob_tail,
    input  wire core_pkg::sq_ptr                        in_sq_tail,
    input  wire core_pkg::cdb_packet [core_pkg::cdb_n-1:0] cdb_in,
    input  wire branch_pkg::br_task                     br_task,
    input  wire branch_pkg::br_mask                     rem_b_id,
    output branch_pkg::br_mask                          assigned_b_id,
    output branch_pkg::checkpoint                       cp_out,
    output logic                                        full
);

    import core_pkg::*;
    import branch_pkg::*;

    checkpoint [depth-1:0] entries;
    checkpoint [depth-1:0] next_entries;

    // one bit per slot, set when free
    logic [depth-1:0] free_slots;
    logic [depth-1:0] next_free;
    logic [depth-1:0] stack_gnt;

    logic   is_branch;
    logic   link_en;
    br_mask live_mask;

    // lowest free slot, full when none is left
    psel_gen #(
        .width(depth)
    ) u_slot_sel (
        .req  (free_slots),
        .gnt  (stack_gnt),
        .empty(full)
    );

    assign is_branch = dis_inst.valid && (dis_inst.cond_branch || dis_inst.uncond_branch);

    // jal style branch writing a link register
    assign link_en = dis_inst.uncond_branch && (dis_inst.dest_reg_idx != '0);

    always_comb begin
        next_entries = entries;
        next_free = free_slots;
        cp_out = '0;
        assigned_b_id = '0;
        live_mask = '0;

        // branch resolved correctly
        if (br_task == CLEAR) begin
            for (int i = 0; i < depth; i++) begin
                if (entries[i].valid && (entries[i].b_id == rem_b_id)) begin
                    next_entries[i] = '0;
                    next_free[i] = 1'b1;
                end else if ((entries[i].b_mask & rem_b_id) != '0) begin
                    next_entries[i].b_mask = entries[i].b_mask & ~rem_b_id;
                end
            end
        end

        // mispredicted, return it and drop everything younger
        if (br_task == SQUASH) begin
            for (int i = 0; i < depth; i++) begin
                if (entries[i].valid && (entries[i].b_id == rem_b_id)) begin
                    cp_out = entries[i];
                end
                // own mask holds own id, so the squashed slot goes too
                if ((entries[i].b_mask & rem_b_id) != '0) begin
                    next_entries[i] = '0;
                    next_free[i] = 1'b1;
                end
            end
        end

        // new checkpoint, gnt is zero when full
        if (is_branch) begin
            assigned_b_id = br_mask'(stack_gnt);
            for (int k = 0; k < depth; k++) begin
                if (stack_gnt[k]) begin
                    next_entries[k].valid = 1'b1;
                    next_entries[k].b_id = br_mask'(stack_gnt);
                    next_entries[k].rec_mt = cur_map;
                    next_entries[k].fl_head = in_fl_head;
                    next_entries[k].rob_tail = in_rob_tail;
                    next_entries[k].sq_tail = in_sq_tail;
                    if (link_en) begin
                        next_entries[k].rec_mt[dis_inst.dest_reg_idx].reg_idx = dis_inst.dest_preg;
                        next_entries[k].rec_mt[dis_inst.dest_reg_idx].ready = 1'b0;
                    end
                    next_free[k] = 1'b0;
                end
            end

            // every branch still alive after this cycle, including the new one
            for (int i = 0; i < depth; i++) begin
                live_mask = live_mask | next_entries[i].b_id;
            end
            for (int k = 0; k < depth; k++) begin
                if (stack_gnt[k]) begin
                    next_entries[k].b_mask = live_mask;
                end
            end
        end

        // wakeup in every saved map
        for (int p = 0; p < cdb_n; p++) begin
            for (int j = 0; j < depth; j++) begin
                if (cdb_in[p].valid && next_entries[j].valid &&
                    (next_entries[j].rec_mt[cdb_in[p].reg_idx].reg_idx ==
                     cdb_in[p].p_reg_idx)) begin
                    next_entries[j].rec_mt[cdb_in[p].reg_idx].ready = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            free_slots <= '1;
            for (int i = 0; i < depth; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].b_id <= '0;
                entries[i].b_mask <= '0;
            end
        end else begin
            entries <= next_entries;
            free_slots <= next_free;
        end
    end

endmodule

`default_nettype wire

/* branch_pkg.sv */
`default_nettype none

package branch_pkg;

    import core_pkg::*;

    // branches in flight at once
    localparam int branch_pred_sz = 4;

    // one-hot id, or an OR of ids for dependence
    typedef logic [branch_pred_sz-1:0] br_mask;

    // resolution command from execute
    typedef enum logic [1:0] {
        NOP    = 2'd0,
        CLEAR  = 2'd1,
        SQUASH = 2'd2
    } br_task;

    // one rename map entry
    typedef struct packed {
        phys_reg_idx reg_idx;
        // value produced and on the CDB
        logic ready;
    } map_entry;

    // whole map, indexed by architectural register
    typedef map_entry [arch_reg_sz-1:0] map_vec;

    // state saved at branch dispatch
    typedef struct packed {
        logic valid;
        // own one-hot id
        br_mask b_id;
        // ids of this branch and every older live branch
        br_mask b_mask;
        // map as seen by the branch
        map_vec rec_mt;
        fl_ptr fl_head;
        rob_ptr rob_tail;
        sq_ptr sq_tail;
    } checkpoint;

endpackage

`default_nettype wire

/* core_pkg.sv */
`default_nettype none

package core_pkg;

    // machine sizes
    localparam int arch_reg_sz = 32;
    localparam int phys_reg_sz = 64;
    localparam int rob_sz = 32;
    localparam int sq_sz = 16;

    // results broadcast per cycle
    localparam int cdb_n = 2;

    // register indices
    typedef logic [$clog2(arch_reg_sz)-1:0] arch_reg_idx;
    typedef logic [$clog2(phys_reg_sz)-1:0] phys_reg_idx;

    // free-list head needs one more position than the ROB
    typedef logic [$clog2(rob_sz+1)-1:0] fl_ptr;
    typedef logic [$clog2(rob_sz)-1:0] rob_ptr;
    typedef logic [$clog2(sq_sz)-1:0] sq_ptr;

    // one instruction from decode, already holding its new tag
    typedef struct packed {
        logic valid;
        logic cond_branch;
        logic uncond_branch;
        // zero when nothing is written back
        arch_reg_idx dest_reg_idx;
        phys_reg_idx dest_preg;
    } decoded_packet;

    // writeback broadcast
    typedef struct packed {
        logic valid;
        arch_reg_idx reg_idx;
        phys_reg_idx p_reg_idx;
    } cdb_packet;

endpackage

`default_nettype wire

/* files.f */
core_pkg.sv
branch_pkg.sv
psel_gen.sv
map_table.sv
br_stack.sv
rename_checkpoint_top.sv
tb_rename_checkpoint.sv

/* map_table.sv */
`timescale 1ns/100ps
`default_nettype none

module map_table (
    input  wire logic                                   clock,
    input  wire logic                                   reset,
    input  wire core_pkg::decoded_packet                dis_inst,
    input  wire core_pkg::cdb_packet [core_pkg::cdb_n-1:0] cdb_in,
    input  wire branch_pkg::br_task                     br_task,
    input  wire branch_pkg::checkpoint                  cp_out,
    output branch_pkg::map_vec                          cur_map
);

    import core_pkg::*;
    import branch_pkg::*;

    map_vec next_map;
    logic   rename_en;

    // r0 is never renamed
    assign rename_en = dis_inst.valid && (dis_inst.dest_reg_idx != '0);

    always_comb begin
        next_map = cur_map;

        // misprediction, fall back to the map saved at the branch
        if (br_task == SQUASH) begin
            next_map = cp_out.rec_mt;
        end else if (rename_en) begin
            next_map[dis_inst.dest_reg_idx].reg_idx = dis_inst.dest_preg;
            next_map[dis_inst.dest_reg_idx].ready = 1'b0;
        end

        // wakeup on top of rename or restore
        // a stale tag leaves the entry alone
        for (int p = 0; p < cdb_n; p++) begin
            if (cdb_in[p].valid &&
                (next_map[cdb_in[p].reg_idx].reg_idx == cdb_in[p].p_reg_idx)) begin
                next_map[cdb_in[p].reg_idx].ready = 1'b1;
            end
        end

        // hardwired zero register
        next_map[0].reg_idx = '0;
        next_map[0].ready = 1'b1;
    end

    // identity map out of reset, all values ready
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < arch_reg_sz; i++) begin
                cur_map[i].reg_idx <= phys_reg_idx'(i);
                cur_map[i].ready <= 1'b1;
            end
        end else begin
            cur_map <= next_map;
        end
    end

endmodule

`default_nettype wire

/* psel_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module psel_gen #(
    parameter int width = 4
) (
    input  wire logic [width-1:0] req,
    output logic      [width-1:0] gnt,
    output logic                  empty
);

    logic [width-1:0] req_neg;

    // two's complement keeps only the lowest set bit
    assign req_neg = ~req + width'(1);
    assign gnt = req & req_neg;

    // nothing requested, so no grant
    assign empty = ~|req;

endmodule

`default_nettype wire

/* rename_checkpoint_cases.txt */
# name dv cb ub dreg dpreg fl rob sq c0v c0reg c0tag c1v c1reg c1tag task rem (inputs, hex)
# then expected: b_id cp_valid cp_b_id cp_mask cp_fl cp_rob cp_sq full probe_reg tag ready
ren_r5    1 0 0 05 20 00 00 0 0 00 00 0 00 00 0 0 0 0 0 0 00 00 0 0 05 20 0
cdb_stale 0 0 0 00 00 00 00 0 1 05 05 0 00 00 0 0 0 0 0 0 00 00 0 0 05 20 0
cdb_wake  0 0 0 00 00 00 00 0 0 00 00 1 05 20 0 0 0 0 0 0 00 00 0 0 05 20 1
ren_r7    1 0 0 07 21 00 00 0 0 00 00 0 00 00 0 0 0 0 0 0 00 00 0 0 07 21 0
br0       1 1 0 00 00 0a 03 1 0 00 00 0 00 00 0 0 1 0 0 0 00 00 0 0 07 21 0
ren_r9    1 0 0 09 22 00 00 0 0 00 00 0 00 00 0 0 0 0 0 0 00 00 0 0 09 22 0
br1       1 1 0 00 00 0c 05 2 0 00 00 0 00 00 0 0 2 0 0 0 00 00 0 0 09 22 0
ren_r9b   1 0 0 09 23 00 00 0 0 00 00 0 00 00 0 0 0 0 0 0 00 00 0 0 09 23 0
br2       1 1 0 00 00 0e 07 3 0 00 00 0 00 00 0 0 4 0 0 0 00 00 0 0 09 23 0
br3       1 1 0 00 00 10 09 4 0 00 00 0 00 00 0 0 8 0 0 0 00 00 0 1 09 23 0
br_full   1 1 0 00 00 11 0a 5 0 00 00 0 00 00 0 0 0 0 0 0 00 00 0 1 09 23 0
cdb_r7    0 0 0 00 00 00 00 0 1 07 21 0 00 00 0 0 0 0 0 0 00 00 0 1 07 21 1
sq_b1     0 0 0 00 00 00 00 0 0 00 00 0 00 00 2 2 0 1 2 3 0c 05 2 0 09 22 0
idle_r7   0 0 0 00 00 00 00 0 0 00 00 0 00 00 0 0 0 0 0 0 00 00 0 0 07 21 1
br_a      1 1 0 00 00 11 0a 5 0 00 00 0 00 00 0 0 2 0 0 0 00 00 0 0 09 22 0
br_b      1 1 0 00 00 13 0c 7 0 00 00 0 00 00 0 0 4 0 0 0 00 00 0 0 09 22 0
br_c      1 1 0 00 00 15 0e 8 0 00 00 0 00 00 0 0 8 0 0 0 00 00 0 1 09 22 0
clr_b0    0 0 0 00 00 00 00 0 0 00 00 0 00 00 1 1 0 0 0 0 00 00 0 0 05 20 1
jal_r1    1 0 1 01 30 17 10 9 0 00 00 0 00 00 0 0 1 0 0 0 00 00 0 1 01 30 0
ren_r1    1 0 0 01 31 00 00 0 0 00 00 0 00 00 0 0 0 0 0 0 00 00 0 1 01 31 0
cdb_r1    0 0 0 00 00 00 00 0 1 01 31 0 00 00 0 0 0 0 0 0 00 00 0 1 01 31 1
sq_jal    0 0 0 00 00 00 00 0 0 00 00 0 00 00 2 1 0 1 1 f 17 10 9 0 01 30 0
sq_b3     0 0 0 00 00 00 00 0 0 00 00 0 00 00 2 8 0 1 8 e 15 0e 8 0 01 01 1
br_reuse  1 1 0 00 00 19 12 a 0 00 00 0 00 00 0 0 1 0 0 0 00 00 0 0 09 22 0

/* rename_checkpoint_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_checkpoint_top (
    input  wire logic                                   clock,
    input  wire logic                                   reset,

    // dispatch side
    input  wire core_pkg::decoded_packet                dis_inst,
    input  wire core_pkg::fl_ptr                        in_fl_head,
    input  wire core_pkg::rob_ptr                       in_rob_tail,
    input  wire core_pkg::sq_ptr                        in_sq_tail,

    // writeback
    input  wire core_pkg::cdb_packet [core_pkg::cdb_n-1:0] cdb_in,

    // branch resolution
    input  wire branch_pkg::br_task                     br_task,
    input  wire branch_pkg::br_mask                     rem_b_id,

    output branch_pkg::br_mask                          assigned_b_id,
    output branch_pkg::checkpoint                       cp_out,
    output logic                                        full,
    output branch_pkg::map_vec                          map_out
);

    import branch_pkg::*;

    // live map, also what a new checkpoint records
    map_vec cur_map;

    map_table u_map_table (
        .clock   (clock),
        .reset   (reset),
        .dis_inst(dis_inst),
        .cdb_in  (cdb_in),
        .br_task (br_task),
        .cp_out  (cp_out),
        .cur_map (cur_map)
    );

    br_stack #(
        .depth(branch_pred_sz)
    ) u_br_stack (
        .clock        (clock),
        .reset        (reset),
        .dis_inst     (dis_inst),
        .cur_map      (cur_map),
        .in_fl_head   (in_fl_head),
        .in_rob_tail  (in_rob_tail),
        .in_sq_tail   (in_sq_tail),
        .cdb_in       (cdb_in),
        .br_task      (br_task),
        .rem_b_id     (rem_b_id),
        .assigned_b_id(assigned_b_id),
        .cp_out       (cp_out),
        .full         (full)
    );

    assign map_out = cur_map;

endmodule

`default_nettype wire

/* tb_rename_checkpoint.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rename_checkpoint;

    import core_pkg::*;
    import branch_pkg::*;

    localparam int name_len = 24;
    localparam int max_cycles = 400;
    localparam int reset_limit = 40;

    logic                  clock;
    logic                  reset;
    decoded_packet         dis_inst;
    fl_ptr                 in_fl_head;
    rob_ptr                in_rob_tail;
    sq_ptr                 in_sq_tail;
    cdb_packet [cdb_n-1:0] cdb_in;
    br_task                task_cmd;
    br_mask                rem_b_id;
    br_mask                assigned_b_id;
    checkpoint             cp_out;
    logic                  full;
    map_vec                map_out;

    rename_checkpoint_top DUT (
        .clock        (clock),
        .reset        (reset),
        .dis_inst     (dis_inst),
        .in_fl_head   (in_fl_head),
        .in_rob_tail  (in_rob_tail),
        .in_sq_tail   (in_sq_tail),
        .cdb_in       (cdb_in),
        .br_task      (task_cmd),
        .rem_b_id     (rem_b_id),
        .assigned_b_id(assigned_b_id),
        .cp_out       (cp_out),
        .full         (full),
        .map_out      (map_out)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
    end

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_b_id(input logic [8*name_len-1:0] name, input br_mask exp,
                              input br_mask act);
        if (act !== exp) begin
            $display("ERR %0s assigned_b_id expected %b actual %b", name, exp, act);
            stop_with_failure();
        end
    endtask

    // every field except the saved map
    task automatic check_checkpoint(input logic [8*name_len-1:0] name, input checkpoint exp,
                                    input checkpoint act);
        if ((act.valid !== exp.valid) || (act.b_id !== exp.b_id) ||
            (act.b_mask !== exp.b_mask) || (act.fl_head !== exp.fl_head) ||
            (act.rob_tail !== exp.rob_tail) || (act.sq_tail !== exp.sq_tail)) begin
            $write("ERR %0s cp_out expected v=%b id=%b mask=%b fl=%h rob=%h sq=%h",
                   name, exp.valid, exp.b_id, exp.b_mask, exp.fl_head, exp.rob_tail,
                   exp.sq_tail);
            $display(" actual v=%b id=%b mask=%b fl=%h rob=%h sq=%h",
                     act.valid, act.b_id, act.b_mask, act.fl_head, act.rob_tail, act.sq_tail);
            stop_with_failure();
        end
    endtask

    task automatic check_full(input logic [8*name_len-1:0] name, input logic exp,
                              input logic act);
        if (act !== exp) begin
            $display("ERR %0s full expected %b actual %b", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_map(input logic [8*name_len-1:0] name, input map_entry exp,
                             input map_entry act);
        if (act !== exp) begin
            $display("ERR %0s map_out expected tag %h ready %b actual tag %h ready %b",
                     name, exp.reg_idx, exp.ready, act.reg_idx, act.ready);
            stop_with_failure();
        end
    endtask

    // a right aligned token starts at its highest nonzero byte
    function automatic logic [7:0] first_char(input logic [8*name_len-1:0] token);
        logic [7:0] c;
        c = 8'h00;
        for (int i = 0; i < name_len; i++) begin
            if (token[8*i +: 8] != 8'h00) begin
                c = token[8*i +: 8];
            end
        end
        return c;
    endfunction

    initial begin : run_cases
        int                    fd;
        int                    got;
        int                    cycles;
        int                    case_count;
        int                    probe;
        logic                  done;
        logic [8*name_len-1:0] name;
        logic [8*256-1:0]      skip_line;
        logic [31:0]           f [27];
        decoded_packet         dis;
        cdb_packet [cdb_n-1:0] cdb;
        br_task                cmd;
        checkpoint             exp_cp;
        map_entry              exp_entry;

        dis_inst = '0;
        in_fl_head = '0;
        in_rob_tail = '0;
        in_sq_tail = '0;
        cdb_in = '0;
        task_cmd = NOP;
        rem_b_id = '0;

        fd = $fopen("rename_checkpoint_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open rename_checkpoint_cases.txt");
            stop_with_failure();
        end

        cycles = 0;
        while ((reset !== 1'b0) && (cycles < reset_limit)) begin
            @(posedge clock);
            cycles++;
        end
        if (reset !== 1'b0) begin
            $display("reset was still high after %0d cycles", reset_limit);
            stop_with_failure();
        end

        cycles = 0;
        case_count = 0;
        done = 1'b0;
        while (!done) begin
            if (cycles >= max_cycles) begin
                $display("the cases did not finish within %0d cycles", max_cycles);
                stop_with_failure();
            end
            got = $fscanf(fd, "%s", name);
            if (got != 1) begin
                done = 1'b1;
            end else if (first_char(name) == "#") begin
                got = $fgets(skip_line, fd);
            end else begin
                got = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                              f[9], f[10], f[11], f[12], f[13]);
                got = got + $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                    f[14], f[15], f[16], f[17], f[18], f[19], f[20],
                                    f[21], f[22], f[23], f[24], f[25], f[26]);
                if (got != 27) begin
                    $display("case %0s holds %0d of the 27 expected fields", name, got);
                    stop_with_failure();
                end

                dis.valid = f[0][0];
                dis.cond_branch = f[1][0];
                dis.uncond_branch = f[2][0];
                dis.dest_reg_idx = arch_reg_idx'(f[3]);
                dis.dest_preg = phys_reg_idx'(f[4]);
                cdb[0].valid = f[8][0];
                cdb[0].reg_idx = arch_reg_idx'(f[9]);
                cdb[0].p_reg_idx = phys_reg_idx'(f[10]);
                cdb[1].valid = f[11][0];
                cdb[1].reg_idx = arch_reg_idx'(f[12]);
                cdb[1].p_reg_idx = phys_reg_idx'(f[13]);
                case (f[14][1:0])
                    2'd1: cmd = CLEAR;
                    2'd2: cmd = SQUASH;
                    default: cmd = NOP;
                endcase

                @(posedge clock);
                dis_inst <= dis;
                in_fl_head <= fl_ptr'(f[5]);
                in_rob_tail <= rob_ptr'(f[6]);
                in_sq_tail <= sq_ptr'(f[7]);
                cdb_in <= cdb;
                task_cmd <= cmd;
                rem_b_id <= br_mask'(f[15]);

                // combinational results in the trigger cycle
                #1;
                check_b_id(name, br_mask'(f[16]), assigned_b_id);
                exp_cp = '0;
                exp_cp.valid = f[17][0];
                exp_cp.b_id = br_mask'(f[18]);
                exp_cp.b_mask = br_mask'(f[19]);
                exp_cp.fl_head = fl_ptr'(f[20]);
                exp_cp.rob_tail = rob_ptr'(f[21]);
                exp_cp.sq_tail = sq_ptr'(f[22]);
                check_checkpoint(name, exp_cp, cp_out);

                // registered results settle on this idle edge
                @(posedge clock);
                dis_inst <= '0;
                cdb_in <= '0;
                task_cmd <= NOP;
                rem_b_id <= '0;
                #1;
                check_full(name, f[23][0], full);
                probe = int'(f[24][4:0]);
                exp_entry.reg_idx = phys_reg_idx'(f[25]);
                exp_entry.ready = f[26][0];
                check_map(name, exp_entry, map_out[probe]);

                cycles += 2;
                case_count++;
            end
        end
        $fclose(fd);

        if (case_count == 0) begin
            $display("no case was read from rename_checkpoint_cases.txt");
            stop_with_failure();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
